/* verilog/alu_pkg.sv */
package alu_pkg;

    localparam int xlen = 32;
    localparam int rob_idx_w = 3; // eight tags in flight

    // RV32I register-register functions, codes 10..15 give zero
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_func_t;

    // one queued operation, 71 bits
    typedef struct packed {
        alu_func_t              func;
        logic [xlen-1:0]        rval1;
        logic [xlen-1:0]        rval2;
        logic [rob_idx_w-1:0]   rob_idx;
    } alu_op_t;

    // first set bit of req at or after start, wrapping at n
    // returns start when nothing is set
    function automatic int rr_first(input logic [31:0] req, input int n, input int start);
        int idx;
        int pick;
        pick = start;
        for (int i = n - 1; i >= 0; i--) begin // nearest candidate is checked last
            idx = start + i;
            if (idx >= n) idx = idx - n;
            if (req[idx]) pick = idx;
        end
        return pick;
    endfunction

endpackage

/* verilog/op_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module op_queue #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(DEPTH - 1)) ? '0 : p + 1'b1; // wraps for any depth
    endfunction

    assign in_ready  = (count != cnt_w'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= bump(wr_ptr);
            if (rd_en) rd_ptr <= bump(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pointers meet only when the queue is empty or full
    a_no_write_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        (count <= cnt_w'(DEPTH)) &&
        ((wr_ptr == rd_ptr) == (count == '0 || count == cnt_w'(DEPTH))))
        else $error("op_queue: pointers and count disagree");

endmodule

`default_nettype wire

/* verilog/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import alu_pkg::*; #(
    parameter int LATENCY = 25
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 start,   // one cycle, only while idle
    input  alu_func_t            func,
    input  logic [xlen-1:0]      rval1,
    input  logic [xlen-1:0]      rval2,
    input  logic [rob_idx_w-1:0] rob_idx,
    output logic                 idle,
    output logic                 done,    // held until grant
    output logic [xlen-1:0]      result,
    output logic [rob_idx_w-1:0] result_rob_idx,
    input  logic                 grant
);

    // counter only needs to hold LATENCY-1
    localparam int cnt_w = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic [4:0]       shamt;
    logic [xlen-1:0]  calc;

    assign shamt = rval2[4:0]; // rv32 uses low five bits only

    always_comb begin
        case (func)
            alu_add:  calc = rval1 + rval2;
            alu_sub:  calc = rval1 - rval2;
            alu_and:  calc = rval1 & rval2;
            alu_or:   calc = rval1 | rval2;
            alu_xor:  calc = rval1 ^ rval2;
            alu_slt:  calc = ($signed(rval1) < $signed(rval2)) ? xlen'(1) : '0;
            alu_sltu: calc = (rval1 < rval2) ? xlen'(1) : '0;
            alu_sll:  calc = rval1 << shamt;
            alu_srl:  calc = rval1 >> shamt;                       // zero fill
            alu_sra:  calc = xlen'($signed(rval1) >>> shamt);      // sign fill
            default:  calc = '0;
        endcase
    end

    assign idle = !busy && !done;

    // result and tag captured at start, then just waited out
    always_ff @(posedge clk_in) begin
        if (start) begin
            result         <= calc;
            result_rob_idx <= rob_idx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            if (start) begin
                busy <= (LATENCY > 1);
                done <= (LATENCY == 1);   // single-cycle case skips counting
                cnt  <= cnt_w'(LATENCY - 1);
            end else if (busy) begin
                if (cnt == cnt_w'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;         // LATENCY cycles after start
                end
                cnt <= cnt - 1'b1;
            end else if (done && grant) begin
                done <= 1'b0;             // idle again next cycle
            end
        end
    end

    // dispatcher must only pick an idle unit
    a_start_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        start |-> idle)
        else $error("alu_unit: start while busy");

    // arbiter must only grant a finished unit
    a_grant_when_done: assert property (@(posedge clk_in) disable iff (rst_in)
        grant |-> done)
        else $error("alu_unit: grant without done");

endmodule

`default_nettype wire

/* verilog/unit_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module unit_dispatch import alu_pkg::*; #(
    parameter int NUM_UNITS = 2
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 head_valid,
    output logic                 head_ready,
    input  alu_op_t              head_op,
    input  logic [NUM_UNITS-1:0] unit_idle,
    output logic [NUM_UNITS-1:0] unit_start,
    output alu_func_t            unit_func,
    output logic [xlen-1:0]      unit_rval1,
    output logic [xlen-1:0]      unit_rval2,
    output logic [rob_idx_w-1:0] unit_rob_idx
);

    localparam int ptr_w = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

    logic [ptr_w-1:0] ptr;   // where the search for an idle unit begins
    logic [ptr_w-1:0] sel;
    logic             fire;

    assign sel        = ptr_w'(rr_first(32'(unit_idle), NUM_UNITS, int'(ptr)));
    assign head_ready = |unit_idle;
    assign fire       = head_valid && head_ready;

    always_comb begin
        unit_start = '0;
        if (fire) unit_start[sel] = 1'b1;
    end

    // operation fields go to every unit, only start picks one
    assign unit_func    = head_op.func;
    assign unit_rval1   = head_op.rval1;
    assign unit_rval2   = head_op.rval2;
    assign unit_rob_idx = head_op.rob_idx;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ptr <= '0;
        end else if (fire) begin
            ptr <= (sel == ptr_w'(NUM_UNITS - 1)) ? '0 : sel + 1'b1; // spread the work
        end
    end

    a_start_onehot: assert property (@(posedge clk_in) disable iff (rst_in)
        $onehot0(unit_start) && ((unit_start & ~unit_idle) == '0))
        else $error("unit_dispatch: start not one-hot or to a busy unit");

endmodule

`default_nettype wire

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import alu_pkg::*; #(
    parameter int NUM_UNITS = 2
) (
    input  logic                                 clk_in,
    input  logic                                 rst_in,
    input  logic [NUM_UNITS-1:0]                 unit_done,
    input  logic [NUM_UNITS-1:0][xlen-1:0]       unit_result,
    input  logic [NUM_UNITS-1:0][rob_idx_w-1:0]  unit_rob_idx,
    output logic [NUM_UNITS-1:0]                 unit_grant,
    output logic                                 cdb_valid,
    input  logic                                 cdb_ready,
    output logic [xlen-1:0]                      cdb_data,
    output logic [rob_idx_w-1:0]                 cdb_rob_idx
);

    localparam int ptr_w = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] sel;
    logic             xfer;

    assign sel = ptr_w'(rr_first(32'(unit_done), NUM_UNITS, int'(ptr)));

    assign cdb_valid   = |unit_done;
    assign cdb_data    = unit_result[sel];
    assign cdb_rob_idx = unit_rob_idx[sel];
    assign xfer        = cdb_valid && cdb_ready;

    always_comb begin
        unit_grant = '0;
        if (xfer) unit_grant[sel] = 1'b1; // only with cdb_ready
    end

    // A stalled winner parks the pointer on itself. The search then starts
    // at a unit that is still done, so a newly finished unit cannot take the
    // bus from under a result that is waiting for cdb_ready.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ptr <= '0;
        end else if (xfer) begin
            ptr <= (sel == ptr_w'(NUM_UNITS - 1)) ? '0 : sel + 1'b1;
        end else if (cdb_valid) begin
            ptr <= sel;
        end
    end

    a_grant_onehot: assert property (@(posedge clk_in) disable iff (rst_in)
        $onehot0(unit_grant) && ((unit_grant & ~unit_done) == '0))
        else $error("cdb_arbiter: bad grant");

endmodule

`default_nettype wire

/* verilog/alu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cluster import alu_pkg::*; #(
    parameter int DEPTH     = 4,
    parameter int NUM_UNITS = 2,
    parameter int LATENCY   = 25
) (
    input  logic                 clk_in,
    input  logic                 rst_in,

    // issue side
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  alu_func_t            issue_func,
    input  logic [xlen-1:0]      issue_rval1,
    input  logic [xlen-1:0]      issue_rval2,
    input  logic [rob_idx_w-1:0] issue_rob_idx,

    // common data bus
    output logic                 cdb_valid,
    input  logic                 cdb_ready,
    output logic [xlen-1:0]      cdb_data,
    output logic [rob_idx_w-1:0] cdb_rob_idx
);

    alu_op_t issue_op;
    alu_op_t head_op;
    logic    head_valid;
    logic    head_ready;

    // operation fields shared by all units
    alu_func_t            disp_func;
    logic [xlen-1:0]      disp_rval1;
    logic [xlen-1:0]      disp_rval2;
    logic [rob_idx_w-1:0] disp_rob_idx;

    logic [NUM_UNITS-1:0]                unit_idle;
    logic [NUM_UNITS-1:0]                unit_start;
    logic [NUM_UNITS-1:0]                unit_done;
    logic [NUM_UNITS-1:0]                unit_grant;
    logic [NUM_UNITS-1:0][xlen-1:0]      unit_result;
    logic [NUM_UNITS-1:0][rob_idx_w-1:0] unit_res_rob_idx;

    assign issue_op = '{func: issue_func, rval1: issue_rval1, rval2: issue_rval2,
                        rob_idx: issue_rob_idx};

    op_queue #(
        .payload_t (alu_op_t),
        .DEPTH     (DEPTH)
    ) u_op_queue (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (issue_op),
        .out_valid (head_valid),
        .out_ready (head_ready),
        .out_data  (head_op)
    );

    unit_dispatch #(
        .NUM_UNITS (NUM_UNITS)
    ) u_unit_dispatch (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .head_valid   (head_valid),
        .head_ready   (head_ready),
        .head_op      (head_op),
        .unit_idle    (unit_idle),
        .unit_start   (unit_start),
        .unit_func    (disp_func),
        .unit_rval1   (disp_rval1),
        .unit_rval2   (disp_rval2),
        .unit_rob_idx (disp_rob_idx)
    );

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        alu_unit #(
            .LATENCY (LATENCY)
        ) u_alu_unit (
            .clk_in         (clk_in),
            .rst_in         (rst_in),
            .start          (unit_start[i]),
            .func           (disp_func),
            .rval1          (disp_rval1),
            .rval2          (disp_rval2),
            .rob_idx        (disp_rob_idx),
            .idle           (unit_idle[i]),
            .done           (unit_done[i]),
            .result         (unit_result[i]),
            .result_rob_idx (unit_res_rob_idx[i]),
            .grant          (unit_grant[i])
        );
    end

    cdb_arbiter #(
        .NUM_UNITS (NUM_UNITS)
    ) u_cdb_arbiter (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .unit_done    (unit_done),
        .unit_result  (unit_result),
        .unit_rob_idx (unit_res_rob_idx),
        .unit_grant   (unit_grant),
        .cdb_valid    (cdb_valid),
        .cdb_ready    (cdb_ready),
        .cdb_data     (cdb_data),
        .cdb_rob_idx  (cdb_rob_idx)
    );

endmodule

`default_nettype wire

/* tests/alu_ref_model.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// shift right one bit at a time, fill is the bit shifted in
function automatic logic [31:0] ref_shr(input logic [31:0] v, input int amt,
                                        input logic fill);
    logic [31:0] r;
    r = v;
    for (int i = 0; i < amt; i++) begin
        r = {fill, r[31:1]};
    end
    return r;
endfunction

// signed less-than decided on the sign bits first
function automatic logic ref_lt_signed(input logic [31:0] a, input logic [31:0] b);
    logic lt;
    if (a[31] != b[31]) begin
        lt = a[31];    // the negative one is smaller
    end else begin
        lt = (a < b);  // same sign orders like unsigned
    end
    return lt;
endfunction

// expected result per function code, unused codes give zero
function automatic logic [31:0] ref_alu(input logic [3:0] code, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [31:0] r;
    int amt;
    amt = int'(b % 32); // only the low five bits count
    case (code)
        4'd0:    r = a + b;
        4'd1:    r = a + ~b + 32'd1; // two's complement
        4'd2:    r = a & b;
        4'd3:    r = a | b;
        4'd4:    r = a ^ b;
        4'd5:    r = {31'd0, ref_lt_signed(a, b)};
        4'd6:    r = {31'd0, a < b};
        4'd7:    r = a << amt;
        4'd8:    r = ref_shr(a, amt, 1'b0);
        4'd9:    r = ref_shr(a, amt, a[31]);
        default: r = '0;
    endcase
    return r;
endfunction

`endif

/* tests/tb_alu_cluster.sv */
`timescale 1ns/1ps

module tb_alu_cluster import alu_pkg::*;;

    localparam int latency     = 6;
    localparam int num_ops     = 12 + 6 + 200; // directed, back-pressure, random
    localparam int max_cycles  = 40 * num_ops * latency;
    localparam int drain_limit = 8 * (latency + 2) * 4;

    logic                 clk_in = 1'b0;
    logic                 rst_in;
    logic                 issue_valid;
    logic                 issue_ready;
    alu_func_t            issue_func;
    logic [xlen-1:0]      issue_rval1;
    logic [xlen-1:0]      issue_rval2;
    logic [rob_idx_w-1:0] issue_rob_idx;
    logic                 cdb_valid;
    logic                 cdb_ready;
    logic [xlen-1:0]      cdb_data;
    logic [rob_idx_w-1:0] cdb_rob_idx;

    logic [31:0]          exp_mem [8]; // expected result per tag
    logic [7:0]           pending;
    logic [31:0]          exp_now;
    logic                 pending_now;
    logic [31:0]          held_data;
    logic [2:0]           held_tag;
    logic                 saw_ready_low = 1'b0;
    int                   stall_pct;
    int                   cycle_cnt = 0;
    string                test_name;

    `include "alu_ref_model.svh"

    alu_cluster #(
        .DEPTH     (4),
        .NUM_UNITS (2),
        .LATENCY   (latency)
    ) u_alu_cluster (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_func    (issue_func),
        .issue_rval1   (issue_rval1),
        .issue_rval2   (issue_rval2),
        .issue_rob_idx (issue_rob_idx),
        .cdb_valid     (cdb_valid),
        .cdb_ready     (cdb_ready),
        .cdb_data      (cdb_data),
        .cdb_rob_idx   (cdb_rob_idx)
    );

    always #2 clk_in = ~clk_in;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR %s expected %h actual %h", name, exp, act);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        $display("Verification failed");
        $fatal(1);
    endtask

    // one cycle, then new cdb_ready just after the edge
    task automatic tick();
        @(posedge clk_in);
        #1;
        cdb_ready = ($urandom_range(99) >= stall_pct);
    endtask

    task automatic send_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b);
        int tag;
        int start;
        tag = -1;
        start = $urandom_range(7);
        while (tag < 0) begin
            for (int k = 0; k < 8; k++) begin
                if (tag < 0 && !pending[(start + k) % 8]) tag = (start + k) % 8;
            end
            if (tag < 0) tick(); // all tags in flight
        end
        issue_valid   = 1'b1;
        issue_func    = alu_func_t'(code);
        issue_rval1   = a;
        issue_rval2   = b;
        issue_rob_idx = 3'(tag);
        while (!issue_ready) tick();
        tick();
        issue_valid = 1'b0;
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (pending != '0 && n < limit) begin
            tick();
            n++;
        end
    endtask

    // scoreboard keyed by rob tag
    always @(posedge clk_in) begin
        if (rst_in) begin
            pending <= '0;
        end else begin
            if (issue_valid && issue_ready) begin
                pending[issue_rob_idx] <= 1'b1;
                exp_mem[issue_rob_idx] <= ref_alu(issue_func, issue_rval1, issue_rval2);
            end
            if (cdb_valid && cdb_ready) pending[cdb_rob_idx] <= 1'b0;
        end
    end

    assign exp_now     = exp_mem[cdb_rob_idx];
    assign pending_now = pending[cdb_rob_idx];

    always @(posedge clk_in) begin
        held_data <= cdb_data;
        held_tag  <= cdb_rob_idx;
        if (!rst_in && !issue_ready) saw_ready_low <= 1'b1;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) report_failure("run did not finish in time");
    end

    a_reset_quiet: assert property (@(posedge clk_in) rst_in |=> !cdb_valid)
        else report_failure("cdb_valid high during or right after reset");

    a_ready_after_reset: assert property (@(posedge clk_in) $fell(rst_in) |-> issue_ready)
        else report_failure("issue_ready low after reset");

    a_tag_pending: assert property (@(posedge clk_in) disable iff (rst_in)
        (cdb_valid && cdb_ready) |-> pending_now)
        else report_failure($sformatf("tag %0d returned while not pending",
                                      $sampled(cdb_rob_idx)));

    a_result_value: assert property (@(posedge clk_in) disable iff (rst_in)
        (cdb_valid && cdb_ready && pending_now) |-> (cdb_data == exp_now))
        else report_mismatch(test_name, $sampled(exp_now), $sampled(cdb_data));

    // stalled bus keeps its data and tag
    a_hold_data: assert property (@(posedge clk_in) disable iff (rst_in)
        (cdb_valid && !cdb_ready) |=> (cdb_valid && cdb_data == held_data))
        else report_mismatch({test_name, " hold"}, $sampled(held_data), $sampled(cdb_data));

    a_hold_tag: assert property (@(posedge clk_in) disable iff (rst_in)
        (cdb_valid && !cdb_ready) |=> (cdb_rob_idx == held_tag))
        else report_mismatch({test_name, " hold tag"}, 32'($sampled(held_tag)),
                             32'($sampled(cdb_rob_idx)));

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'h4c0ed82f));
        test_name     = "reset";
        stall_pct     = 0;
        rst_in        = 1'b1;
        issue_valid   = 1'b0;
        issue_func    = alu_add;
        issue_rval1   = '0;
        issue_rval2   = '0;
        issue_rob_idx = '0;
        cdb_ready     = 1'b1;
        repeat (8) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        tick();

        test_name = "directed";
        send_op(alu_add,  32'h7fff_ffff, 32'h0000_0001); // signed overflow
        send_op(alu_sub,  32'h0000_0000, 32'h0000_0001);
        send_op(alu_and,  32'hf0f0_f0f0, 32'h0ff0_0ff0);
        send_op(alu_or,   32'hf0f0_0000, 32'h0000_0f0f);
        send_op(alu_xor,  32'haaaa_5555, 32'hffff_0000);
        send_op(alu_slt,  32'hffff_ffff, 32'h0000_0001); // -1 < 1
        send_op(alu_sltu, 32'hffff_ffff, 32'h0000_0001);
        send_op(alu_slt,  32'h0000_0001, 32'hffff_ffff);
        send_op(alu_sltu, 32'h0000_0001, 32'hffff_ffff);
        send_op(alu_sll,  32'h0000_0001, 32'h0000_0021); // shamt 33 masks to 1
        send_op(alu_srl,  32'h8000_0000, 32'h0000_0024);
        send_op(alu_sra,  32'h8000_0000, 32'h0000_001f);
        drain(drain_limit);

        // hold the bus off until the queue backs up
        test_name = "backpressure";
        stall_pct = 100;
        tick();
        repeat (6) send_op(4'($urandom_range(9)), $urandom, $urandom);
        repeat (latency + 4) tick();
        stall_pct = 0;
        drain(drain_limit);

        test_name = "random";
        stall_pct = 30;
        for (int i = 0; i < 200; i++) begin
            repeat ($urandom_range(3)) tick();
            a = $urandom;
            b = ($urandom_range(1) == 0) ? $urandom : 32'($urandom_range(40));
            send_op(4'($urandom_range(9)), a, b);
        end
        stall_pct = 0;
        drain(drain_limit);

        if (pending != '0) begin
            report_failure("tags still pending after the drain");
        end else if (!saw_ready_low) begin
            report_failure("issue_ready never fell under back-pressure");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* alu_cluster.f */
+incdir+tests
verilog/alu_pkg.sv
verilog/op_queue.sv
verilog/alu_unit.sv
verilog/unit_dispatch.sv
verilog/cdb_arbiter.sv
verilog/alu_cluster.sv
tests/tb_alu_cluster.sv
